/* hw/mult_defines.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths and counts for the shift-add multiplier
// include wherever a size is needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MULT_DEFINES_SVH
`define MULT_DEFINES_SVH

// operand width, only 8 is exercised
`define MULT_WIDTH 8

// one add/sub plus one shift per multiplier bit
`define MULT_STEPS `MULT_WIDTH

// seven-segment display, segments a..g
`define SEG_WIDTH 7

`endif

/* hw/multPkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the multiplier design
// import inside module bodies
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mult_defines.svh"

package multPkg;

    // A, B and the switch operand S
    typedef logic [`MULT_WIDTH-1:0] operandT;

    // {A, B} product
    typedef logic [2*`MULT_WIDTH-1:0] productT;

    // one hex digit
    typedef logic [3:0] nibbleT;

    // active low, bit 0 is segment a, bit 6 is segment g
    typedef logic [`SEG_WIDTH-1:0] segT;

    // zero glyph, all segments lit except g
    parameter segT segZero = 7'b1000000;

    // controller states
    typedef enum logic [2:0] {idle, clearLoad, addStep, shiftStep, hold} ctrlStateT;

    // counts multiplier bits, wide enough for MULT_STEPS = 8
    typedef logic [2:0] stepCountT;

endpackage

/* hw/multCtrlIf.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// strobes from controller to datapath
// plus the multiplier bit coming back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface multCtrlIf;

    // clear A and X, load B from S
    logic clrLd;
    // add S into A when mBit set
    logic add;
    // subtract S from A, last step only
    logic sub;
    // arithmetic right shift of {X, A, B}
    logic shift;
    // current low bit of B
    logic mBit;

    modport ctl (
        output clrLd,
        output add,
        output sub,
        output shift,
        input  mBit
    );

    modport dp (
        input  clrLd,
        input  add,
        input  sub,
        input  shift,
        output mBit
    );

endinterface

/* hw/hexDriver.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hex digit to active-low 7-segment pattern
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hexDriver (
    input  multPkg::nibbleT nibble,
    output multPkg::segT    seg
);
    import multPkg::*;

    // pattern bits are g f e d c b a, low lights a segment
    always_comb begin
        unique case (nibble)
            4'h0: seg = segZero;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            // upper case A
            4'hA: seg = 7'b0001000;
            // lower case b
            4'hB: seg = 7'b0000011;
            4'hC: seg = 7'b1000110;
            // lower case d
            4'hD: seg = 7'b0100001;
            4'hE: seg = 7'b0000110;
            4'hF: seg = 7'b0001110;
            default: seg = '1;
        endcase
    end

endmodule

/* hw/multControl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sequencer for the shift-add multiplier
// drives the strobes of multCtrlIf
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mult_defines.svh"

module multControl (
    input logic Clk,
    input logic reset,
    input logic Run,
    input logic ClearA_LoadB,
    multCtrlIf.ctl ctrl
);
    import multPkg::*;

    // index of the step that subtracts instead of adds
    localparam stepCountT lastStep = stepCountT'(`MULT_STEPS - 1);

    ctrlStateT state;
    ctrlStateT stateNext;
    stepCountT stepCount;
    stepCountT countNext;
    logic onLastStep;

    assign onLastStep = (stepCount == lastStep);

    // state and step counter
    always_ff @(posedge Clk) begin
        if (reset) begin
            state     <= idle;
            stepCount <= '0;
        end else begin
            state     <= stateNext;
            stepCount <= countNext;
        end
    end

    always_comb begin
        stateNext = state;
        countNext = stepCount;
        unique case (state)
            idle: begin
                // clear/load wins over run
                if (ClearA_LoadB) begin
                    stateNext = clearLoad;
                end else if (Run) begin
                    stateNext = addStep;
                    countNext = '0;
                end
            end
            clearLoad: begin
                // single cycle pulse
                stateNext = idle;
            end
            addStep: begin
                stateNext = shiftStep;
            end
            shiftStep: begin
                if (onLastStep) begin
                    stateNext = hold;
                end else begin
                    stateNext = addStep;
                    countNext = stepCount + 1'b1;
                end
            end
            hold: begin
                // wait for the button to come back up
                if (!Run) begin
                    stateNext = idle;
                end
            end
            default: begin
                stateNext = idle;
            end
        endcase
    end

    // strobes follow the state
    // datapath applies add/sub only when its multiplier bit is set
    always_comb begin
        ctrl.clrLd = (state == clearLoad);
        ctrl.shift = (state == shiftStep);
        ctrl.add   = (state == addStep) && !onLastStep;
        ctrl.sub   = (state == addStep) && onLastStep;
    end

endmodule

/* hw/shiftAddUnit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// A, B and X registers of the multiplier
// acts on the strobes from multControl
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mult_defines.svh"

module shiftAddUnit (
    input  logic            Clk,
    input  logic            reset,
    input  multPkg::operandT S,
    multCtrlIf.dp           ctrl,
    output multPkg::operandT aReg,
    output multPkg::operandT bReg,
    output logic            xBit
);
    import multPkg::*;

    // one extra bit so X can take the true sign of the result
    logic [`MULT_WIDTH:0] aExt;
    logic [`MULT_WIDTH:0] sExt;
    logic [`MULT_WIDTH:0] sumExt;
    logic [`MULT_WIDTH:0] diffExt;
    logic                 doAdd;
    logic                 doSub;
    productT              abShifted;

    // sign extend both operands
    assign aExt = {aReg[`MULT_WIDTH-1], aReg};
    assign sExt = {S[`MULT_WIDTH-1], S};

    assign sumExt  = aExt + sExt;
    assign diffExt = aExt - sExt;

    // strobe only counts when the multiplier bit is set
    assign doAdd = ctrl.add && bReg[0];
    assign doSub = ctrl.sub && bReg[0];

    // {X, A, B} >> 1 with X kept as the sign
    // low bit of A drops into the top of B
    assign abShifted = {xBit, aReg, bReg[`MULT_WIDTH-1:1]};

    assign ctrl.mBit = bReg[0];

    always_ff @(posedge Clk) begin
        if (reset) begin
            aReg <= '0;
            bReg <= '0;
            xBit <= 1'b0;
        end else if (ctrl.clrLd) begin
            // new multiplier from the switches
            aReg <= '0;
            bReg <= S;
            xBit <= 1'b0;
        end else if (doAdd) begin
            aReg <= sumExt[`MULT_WIDTH-1:0];
            xBit <= sumExt[`MULT_WIDTH];
        end else if (doSub) begin
            // last step, multiplier sign bit has negative weight
            aReg <= diffExt[`MULT_WIDTH-1:0];
            xBit <= diffExt[`MULT_WIDTH];
        end else if (ctrl.shift) begin
            {aReg, bReg} <= abShifted;
        end
    end

endmodule

/* hw/multTop.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// board top: controller, datapath, displays
// A and B shown on four hex digits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mult_defines.svh"

module multTop (
    input  logic                   Clk,
    input  logic                   Reset,
    input  logic                   Run,
    input  logic                   ClearA_LoadB,
    input  logic [`MULT_WIDTH-1:0] S,
    output logic [`SEG_WIDTH-1:0]  AhexU,
    output logic [`SEG_WIDTH-1:0]  AhexL,
    output logic [`SEG_WIDTH-1:0]  BhexU,
    output logic [`SEG_WIDTH-1:0]  BhexL,
    output logic [`MULT_WIDTH-1:0] Aval,
    output logic [`MULT_WIDTH-1:0] Bval,
    output logic                   X
);
    import multPkg::*;

    // decoder outputs before the display registers
    segT aSegU;
    segT aSegL;
    segT bSegU;
    segT bSegL;

    multCtrlIf ctrlBus ();

    multControl uControl (
        .Clk          (Clk),
        .reset        (Reset),
        .Run          (Run),
        .ClearA_LoadB (ClearA_LoadB),
        .ctrl         (ctrlBus.ctl)
    );

    shiftAddUnit uDatapath (
        .Clk   (Clk),
        .reset (Reset),
        .S     (S),
        .ctrl  (ctrlBus.dp),
        .aReg  (Aval),
        .bReg  (Bval),
        .xBit  (X)
    );

    // high and low digit of each register
    hexDriver uAhexU (.nibble(Aval[7:4]), .seg(aSegU));
    hexDriver uAhexL (.nibble(Aval[3:0]), .seg(aSegL));
    hexDriver uBhexU (.nibble(Bval[7:4]), .seg(bSegU));
    hexDriver uBhexL (.nibble(Bval[3:0]), .seg(bSegL));

    // display registers, one cycle behind Aval and Bval
    always_ff @(posedge Clk) begin
        if (Reset) begin
            AhexU <= segZero;
            AhexL <= segZero;
            BhexU <= segZero;
            BhexL <= segZero;
        end else begin
            AhexU <= aSegU;
            AhexL <= aSegL;
            BhexU <= bSegU;
            BhexL <= bSegL;
        end
    end

endmodule

/* test/multTb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// self-checking testbench for multTop
// run with the vlog.f file list, top multTb
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mult_defines.svh"

module multTb;
    import multPkg::*;

    // reset, clear/load, directed, random, hold
    localparam int numOps = 2 + 7 + 200 + 2;
    // worst case per operation plus reset and spare
    localparam int watchdogCycles = numOps * 40 + 500;

    logic    Clk;
    logic    Reset;
    logic    Run;
    logic    ClearA_LoadB;
    operandT S;
    segT     AhexU;
    segT     AhexL;
    segT     BhexU;
    segT     BhexL;
    operandT Aval;
    operandT Bval;
    logic    X;

    // expected values handed to the compare process
    event    checkNow;
    string   expName;
    productT expProd;
    logic    expHex;

    int errorCount;
    int checkCount;
    int testCount;
    int errorsAtStart;

    multTop i_dut (
        .Clk          (Clk),
        .Reset        (Reset),
        .Run          (Run),
        .ClearA_LoadB (ClearA_LoadB),
        .S            (S),
        .AhexU        (AhexU),
        .AhexL        (AhexL),
        .BhexU        (BhexU),
        .BhexL        (BhexL),
        .Aval         (Aval),
        .Bval         (Bval),
        .X            (X)
    );

    // signed 8x8 product as 16-bit two's complement
    function automatic productT refProduct(input operandT a, input operandT b);
        int sa;
        int sb;
        sa = $signed(a);
        sb = $signed(b);
        return productT'(sa * sb);
    endfunction

    // run started with A already holding a value
    // A lands in the low half after eight shifts, so it simply adds
    function automatic productT refResume(input operandT aStart, input operandT s,
                                          input operandT b);
        int sa;
        sa = $signed(aStart);
        return productT'(sa + int'($signed(refProduct(s, b))));
    endfunction

    // conventional active-low glyphs, bits g..a
    function automatic segT refSeg(input nibbleT n);
        case (n)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'hA: return 7'b0001000;
            4'hB: return 7'b0000011;
            4'hC: return 7'b1000110;
            4'hD: return 7'b0100001;
            4'hE: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    task automatic checkEq(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // compare process, woken once per requested check
    initial begin
        forever begin
            @(checkNow);
            checkEq({expName, " Aval"}, 16'(expProd[15:8]), 16'(Aval));
            checkEq({expName, " Bval"}, 16'(expProd[7:0]), 16'(Bval));
            // X is the sign of the product
            checkEq({expName, " X"}, 16'(expProd[15]), 16'(X));
            if (expHex) begin
                checkEq({expName, " AhexU"}, 16'(refSeg(expProd[15:12])), 16'(AhexU));
                checkEq({expName, " AhexL"}, 16'(refSeg(expProd[11:8])), 16'(AhexL));
                checkEq({expName, " BhexU"}, 16'(refSeg(expProd[7:4])), 16'(BhexU));
                checkEq({expName, " BhexL"}, 16'(refSeg(expProd[3:0])), 16'(BhexL));
            end
        end
    end

    // clock, 20 ns period
    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    initial begin
        stepCountT stuckStep;
        ctrlStateT stuckState;
        repeat (watchdogCycles) @(posedge Clk);
        stuckStep  = i_dut.uControl.stepCount;
        stuckState = i_dut.uControl.state;
        $display("run timed out after %0d cycles, controller in %s at step %0d",
                 watchdogCycles, stuckState.name(), stuckStep);
        $display("TESTS FAILED");
        $finish;
    end

    // drive point is 2 ns past the rising edge
    task automatic waitEdges(input int n);
        repeat (n) @(posedge Clk);
        #2;
    endtask

    task automatic checkResult(input string name, input productT prod, input logic withHex);
        expName = name;
        expProd = prod;
        expHex  = withHex;
        -> checkNow;
        // let the compare process finish first
        #1;
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (errorCount == errorsAtStart) begin
            $display("test %s done, ok", name);
        end else begin
            $display("test %s done, %0d errors", name, errorCount - errorsAtStart);
        end
        errorsAtStart = errorCount;
    endtask

    // multiplier goes into B through clear/load
    task automatic loadMultiplier(input operandT b);
        S = b;
        ClearA_LoadB = 1'b1;
        waitEdges(1);
        ClearA_LoadB = 1'b0;
        // loaded on the edge after sampling
        waitEdges(1);
    endtask

    task automatic runProduct(input string name, input operandT s, input operandT b);
        loadMultiplier(b);
        S = s;
        Run = 1'b1;
        waitEdges(1);
        Run = 1'b0;
        // result fixed 17 edges after the sampling edge
        waitEdges(16);
        checkResult(name, refProduct(s, b), 1'b0);
        // displays lag one cycle
        waitEdges(1);
        checkResult(name, refProduct(s, b), 1'b1);
    endtask

    initial begin
        int      seedDummy;
        operandT sRand;
        operandT bRand;
        productT first;
        productT second;

        Reset        = 1'b1;
        Run          = 1'b0;
        ClearA_LoadB = 1'b0;
        S            = '0;
        errorCount   = 0;
        checkCount   = 0;
        testCount    = 0;
        errorsAtStart = 0;
        seedDummy    = $urandom(63);

        repeat (5) @(posedge Clk);
        #2;
        Reset = 1'b0;
        checkResult("reset", 16'h0000, 1'b1);
        finishTest("reset");

        loadMultiplier(8'h96);
        checkResult("clear load", 16'h0096, 1'b0);
        finishTest("clear load");

        runProduct("zero", 8'h00, 8'h5B);
        finishTest("zero");
        runProduct("one", 8'h01, 8'hB3);
        finishTest("one");
        runProduct("minus one squared", 8'hFF, 8'hFF);
        finishTest("minus one squared");
        runProduct("min squared", 8'h80, 8'h80);
        finishTest("min squared");
        runProduct("max times min", 8'h7F, 8'h80);
        finishTest("max times min");
        runProduct("alternating 55 AA", 8'h55, 8'hAA);
        finishTest("alternating 55 AA");
        runProduct("alternating AA 55", 8'hAA, 8'h55);
        finishTest("alternating AA 55");

        for (int i = 0; i < 200; i++) begin
            sRand = operandT'($urandom);
            bRand = operandT'($urandom);
            runProduct($sformatf("random %0d", i), sRand, bRand);
        end
        finishTest("random");

        // Run kept high through hold
        loadMultiplier(8'hC3);
        S = 8'h2D;
        Run = 1'b1;
        first = refProduct(8'h2D, 8'hC3);
        waitEdges(18);
        checkResult("hold first", first, 1'b1);
        waitEdges(6);
        checkResult("hold stable", first, 1'b1);
        Run = 1'b0;
        waitEdges(1);
        // second press starts from the old {A, B}
        S = 8'h6B;
        Run = 1'b1;
        second = refResume(first[15:8], 8'h6B, first[7:0]);
        waitEdges(18);
        checkResult("hold second", second, 1'b1);
        Run = 1'b0;
        waitEdges(2);
        finishTest("hold");

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hw
hw/multPkg.sv
hw/multCtrlIf.sv
hw/hexDriver.sv
hw/multControl.sv
hw/shiftAddUnit.sv
hw/multTop.sv
test/multTb.sv

/* Makefile */
# Verilator build and run for the shift-add multiplier

BUILD = obj_dir
LOG = sim.log

.PHONY: all run lint clean

all: run

$(BUILD)/VmultTb: vlog.f hw/*.sv hw/*.svh test/*.sv
	verilator --binary --timing -f vlog.f --top-module multTb -Mdir $(BUILD) -o VmultTb

# pass only if the log holds the pass line
run: $(BUILD)/VmultTb
	./$(BUILD)/VmultTb > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

lint:
	verilator --lint-only --timing -f vlog.f --top-module multTop

clean:
	rm -rf $(BUILD) $(LOG)
